//--- hw/BatchPkg.sv
package BatchPkg;

    localparam int coefWidth = 16;
    localparam int stateWidth = 24;
    localparam int fracBits = 14;
    localparam int maxChannels = 4;
    localparam int maxBits = 4;

    typedef struct packed {
        logic signed [stateWidth-1:0] re;
        logic signed [stateWidth-1:0] im;
    } complexT;

    typedef struct packed {
        logic signed [coefWidth-1:0] re;
        logic signed [coefWidth-1:0] im;
    } coefT;

    // Role rotation of the four sample buffers
    typedef enum logic [1:0] {phase0, phase1, phase2, phase3} phaseT;

    typedef enum logic [1:0] {fillWait, streaming, reserved} batchStateT;

    // Per-bit input coefficients, Q.14
    localparam coefT inputCoef [maxChannels][maxBits] = '{
        '{'{16'sd1200, -16'sd310}, '{16'sd2400, -16'sd620},
          '{16'sd4800, -16'sd1240}, '{16'sd600, -16'sd155}},
        '{'{16'sd900, 16'sd450}, '{16'sd1800, 16'sd900},
          '{16'sd3600, 16'sd1800}, '{16'sd450, 16'sd225}},
        '{'{16'sd700, -16'sd200}, '{16'sd1400, -16'sd400},
          '{16'sd2800, -16'sd800}, '{16'sd350, -16'sd100}},
        '{'{16'sd1000, 16'sd0}, '{16'sd2000, 16'sd0},
          '{16'sd4000, 16'sd0}, '{16'sd500, 16'sd0}}
    };

    // Pole factors, all with magnitude below one
    localparam coefT forwardFactor [maxChannels] = '{
        '{16'sd14746, 16'sd3277}, '{16'sd13926, -16'sd4915},
        '{16'sd15237, 16'sd1638}, '{16'sd12288, 16'sd6554}
    };
    localparam coefT backwardFactor [maxChannels] = '{
        '{16'sd14746, -16'sd3277}, '{16'sd13926, 16'sd4915},
        '{16'sd15237, -16'sd1638}, '{16'sd12288, -16'sd6554}
    };

    localparam coefT forwardWeight [maxChannels] = '{
        '{16'sd8192, 16'sd1024}, '{16'sd6144, -16'sd2048},
        '{16'sd4096, 16'sd3072}, '{16'sd8192, 16'sd0}
    };
    localparam coefT backwardWeight [maxChannels] = '{
        '{16'sd8192, -16'sd1024}, '{16'sd6144, 16'sd2048},
        '{16'sd4096, -16'sd3072}, '{16'sd8192, 16'sd0}
    };

    // Full-width product, arithmetic shift, wrap to state width
    function automatic complexT cmul(complexT a, coefT b);
        logic signed [stateWidth+coefWidth:0] prodRe;
        logic signed [stateWidth+coefWidth:0] prodIm;
        complexT r;
        prodRe = a.re * b.re - a.im * b.im;
        prodIm = a.re * b.im + a.im * b.re;
        r.re = stateWidth'(prodRe >>> fracBits);
        r.im = stateWidth'(prodIm >>> fracBits);
        return r;
    endfunction

    function automatic complexT cadd(complexT a, complexT b);
        complexT r;
        r.re = a.re + b.re;
        r.im = a.im + b.im;
        return r;
    endfunction

endpackage

//--- hw/BatchRam.sv
`timescale 1ns/1ps

module BatchRam #(
    parameter int depth = 32,
    parameter int dataWidth = 8
) (
    input  logic                     clk,
    input  logic                     writeEn,
    input  logic [$clog2(depth)-1:0] writeAddr,
    input  logic [dataWidth-1:0]     writeData,
    input  logic [$clog2(depth)-1:0] readAddr,
    output logic [dataWidth-1:0]     writeSideData,
    output logic [dataWidth-1:0]     readData
);

    logic [dataWidth-1:0] mem [depth];

    // Both ports read old data on a same-address write
    always_ff @(posedge clk) begin
        if (writeEn) begin
            mem[writeAddr] <= writeData;
        end
        writeSideData <= mem[writeAddr];
        readData <= mem[readAddr];
    end

endmodule

//--- hw/CoeffLut.sv
`timescale 1ns/1ps

module CoeffLut #(
    parameter int sampleBits = 3,
    parameter int channel = 0
) (
    input  logic [sampleBits-1:0] sample,
    output BatchPkg::complexT     value
);

    BatchPkg::coefT coef;

    // Each bit adds or subtracts its coefficient
    always_comb begin
        logic signed [BatchPkg::stateWidth-1:0] sumRe;
        logic signed [BatchPkg::stateWidth-1:0] sumIm;
        sumRe = '0;
        sumIm = '0;
        coef = '0;
        for (int i = 0; i < sampleBits; i++) begin
            coef = BatchPkg::inputCoef[channel][i];
            if (sample[i]) begin
                sumRe = sumRe + coef.re;
                sumIm = sumIm + coef.im;
            end else begin
                sumRe = sumRe - coef.re;
                sumIm = sumIm - coef.im;
            end
        end
        value.re = sumRe;
        value.im = sumIm;
    end

endmodule

//--- hw/ComplexRecursion.sv
`timescale 1ns/1ps

module ComplexRecursion #(
    parameter int channel = 0,
    parameter bit backward = 1'b0
) (
    input  logic               clk,
    input  logic               rstN,
    input  logic               load,
    input  BatchPkg::complexT  loadValue,
    input  BatchPkg::complexT  in,
    output BatchPkg::complexT  state
);

    localparam BatchPkg::coefT factor = backward ? BatchPkg::backwardFactor[channel]
                                                 : BatchPkg::forwardFactor[channel];

    BatchPkg::complexT scaled;

    assign scaled = BatchPkg::cmul(state, factor);

    always_ff @(posedge clk) begin
        if (!rstN) begin
            state <= '0;
        end else if (load) begin
            state <= BatchPkg::cadd(loadValue, in);
        end else begin
            state <= BatchPkg::cadd(scaled, in);
        end
    end

    // Load comes from the control pipeline and must be defined
    loadKnown: assert property (@(posedge clk) rstN |-> !$isunknown(load));

endmodule

//--- hw/BatchControl.sv
`timescale 1ns/1ps

module BatchControl #(
    parameter int depth = 32
) (
    input  logic                     clk,
    input  logic                     rstN,
    output logic [$clog2(depth)-1:0] batchCount,
    output logic [$clog2(depth)-1:0] batchCountRev,
    output BatchPkg::phaseT          phase,
    output logic                     lookaheadLoad,
    output logic                     outValid
);

    localparam int addrWidth = $clog2(depth);
    localparam logic [addrWidth-1:0] lastCount = addrWidth'(depth - 1);

    BatchPkg::batchStateT state;
    logic [1:0] filled;
    // Streaming flag delayed to the output latency
    logic [3:0] validPipe;
    logic wrap;

    assign wrap = batchCount == lastCount;
    assign batchCountRev = lastCount - batchCount;
    assign outValid = validPipe[3];

    always_ff @(posedge clk) begin
        if (!rstN) begin
            batchCount <= '0;
            phase <= BatchPkg::phase0;
            lookaheadLoad <= 1'b0;
            state <= BatchPkg::fillWait;
            filled <= '0;
            validPipe <= '0;
        end else begin
            batchCount <= wrap ? '0 : batchCount + 1'b1;
            if (wrap) begin
                phase <= BatchPkg::phaseT'(phase + 2'd1);
            end
            lookaheadLoad <= wrap;
            validPipe <= {validPipe[2:0], state == BatchPkg::streaming};
            case (state)
                BatchPkg::fillWait: begin
                    if (wrap) begin
                        filled <= filled + 2'd1;
                        if (filled == 2'd3) begin
                            state <= BatchPkg::streaming;
                        end
                    end
                end
                BatchPkg::streaming: begin
                    state <= BatchPkg::streaming;
                end
                default: begin
                    state <= BatchPkg::fillWait;
                end
            endcase
        end
    end

    phaseOnWrap: assert property (@(posedge clk) disable iff (!rstN)
        (phase != $past(phase)) |-> ($past(batchCount) == lastCount));

    stateLegal: assert property (@(posedge clk) disable iff (!rstN)
        state != BatchPkg::reserved);

endmodule

//--- hw/FilterChannel.sv
`timescale 1ns/1ps

module FilterChannel #(
    parameter int depth = 32,
    parameter int sampleBits = 3,
    parameter int channel = 0
) (
    input  logic                                  clk,
    input  logic                                  rstN,
    input  BatchPkg::phaseT                       phase,
    input  logic [$clog2(depth)-1:0]              batchCount,
    input  logic [$clog2(depth)-1:0]              batchCountRev,
    input  logic                                  lookaheadLoad,
    input  logic [sampleBits-1:0]                 lookaheadSample,
    input  logic [sampleBits-1:0]                 forwardSample,
    input  logic [sampleBits-1:0]                 backwardSample,
    output logic signed [BatchPkg::stateWidth-1:0] contribution
);

    localparam int addrWidth = $clog2(depth);

    BatchPkg::complexT laIn, fwIn, bwIn, fwGated;
    BatchPkg::complexT laState, fwState, bwState;
    BatchPkg::complexT fwWeighted, bwWeighted;
    logic fwRun, fwStart;
    logic [addrWidth-1:0] fwAddr, bwAddr;
    logic writeBank;
    logic [BatchPkg::stateWidth-1:0] fwRead, bwRead;

    CoeffLut #(.sampleBits(sampleBits), .channel(channel)) lookaheadLut (
        .sample(lookaheadSample), .value(laIn));
    CoeffLut #(.sampleBits(sampleBits), .channel(channel)) forwardLut (
        .sample(forwardSample), .value(fwIn));
    CoeffLut #(.sampleBits(sampleBits), .channel(channel)) backwardLut (
        .sample(backwardSample), .value(bwIn));

    // Forward path only sees zero until the first real batch arrives
    assign fwStart = lookaheadLoad && phase == BatchPkg::phase3;
    assign fwGated = (fwRun || fwStart) ? fwIn : '0;

    always_ff @(posedge clk) begin
        if (!rstN) begin
            fwRun <= 1'b0;
        end else if (fwStart) begin
            fwRun <= 1'b1;
        end
    end

    ComplexRecursion #(.channel(channel), .backward(1'b1)) lookahead (
        .clk, .rstN, .load(lookaheadLoad), .loadValue('0), .in(laIn), .state(laState));

    ComplexRecursion #(.channel(channel), .backward(1'b0)) forward (
        .clk, .rstN, .load(1'b0), .loadValue('0), .in(fwGated), .state(fwState));

    // The lookahead state register holds last batch's final value here
    ComplexRecursion #(.channel(channel), .backward(1'b1)) backward (
        .clk, .rstN, .load(lookaheadLoad), .loadValue(laState), .in(bwIn), .state(bwState));

    // Results land one cycle after their samples
    always_ff @(posedge clk) begin
        if (!rstN) begin
            fwAddr <= '0;
            bwAddr <= '0;
            writeBank <= 1'b0;
        end else begin
            fwAddr <= batchCount;
            bwAddr <= batchCountRev;
            writeBank <= phase[0];
        end
    end

    assign fwWeighted = BatchPkg::cmul(fwState, BatchPkg::forwardWeight[channel]);
    assign bwWeighted = BatchPkg::cmul(bwState, BatchPkg::backwardWeight[channel]);

    // Half selected by writeBank is filled, the other half is combined
    BatchRam #(.depth(2 * depth), .dataWidth(BatchPkg::stateWidth)) forwardStore (
        .clk,
        .writeEn(1'b1),
        .writeAddr({writeBank, fwAddr}),
        .writeData(fwWeighted.re),
        .readAddr({~writeBank, fwAddr}),
        .writeSideData(),
        .readData(fwRead)
    );

    BatchRam #(.depth(2 * depth), .dataWidth(BatchPkg::stateWidth)) backwardStore (
        .clk,
        .writeEn(1'b1),
        .writeAddr({writeBank, bwAddr}),
        .writeData(bwWeighted.re),
        .readAddr({~writeBank, fwAddr}),
        .writeSideData(),
        .readData(bwRead)
    );

    assign contribution = $signed(fwRead) + $signed(bwRead);

    bankSwapAtStart: assert property (@(posedge clk) disable iff (!rstN)
        (writeBank != $past(writeBank)) |-> (fwAddr == '0));

endmodule

//--- hw/BatchReconstructor.sv
`timescale 1ns/1ps

module BatchReconstructor #(
    parameter int depth = 32,
    parameter int sampleBits = 3,
    parameter int channels = 3
) (
    input  logic                                  clk,
    input  logic                                  rstN,
    input  logic [sampleBits-1:0]                 sampleIn,
    output logic signed [BatchPkg::stateWidth-1:0] outData,
    output logic                                  outValid
);

    localparam int addrWidth = $clog2(depth);

    logic [addrWidth-1:0] batchCount, batchCountRev;
    logic [addrWidth-1:0] countD, countRevD;
    BatchPkg::phaseT phase, phaseD;
    logic lookaheadLoad, loadD;
    logic [sampleBits-1:0] writeSide [4];
    logic [sampleBits-1:0] readSide [4];
    logic [1:0] laSel, coSel;
    logic [sampleBits-1:0] laSample, fwSample, bwSample;
    logic signed [BatchPkg::stateWidth-1:0] contrib [channels];
    logic signed [BatchPkg::stateWidth-1:0] channelSum;

    BatchControl #(.depth(depth)) control (
        .clk, .rstN, .batchCount, .batchCountRev, .phase, .lookaheadLoad, .outValid);

    for (genvar b = 0; b < 4; b++) begin : gBuffer
        BatchRam #(.depth(depth), .dataWidth(sampleBits)) buffer (
            .clk,
            .writeEn(phase == BatchPkg::phaseT'(b)),
            .writeAddr(batchCount),
            .writeData(sampleIn),
            .readAddr(batchCountRev),
            .writeSideData(writeSide[b]),
            .readData(readSide[b])
        );
    end

    // Control delayed to line up with the registered buffer reads
    always_ff @(posedge clk) begin
        if (!rstN) begin
            countD <= '0;
            countRevD <= '0;
            phaseD <= BatchPkg::phase0;
            loadD <= 1'b0;
        end else begin
            countD <= batchCount;
            countRevD <= batchCountRev;
            phaseD <= phase;
            loadD <= lookaheadLoad;
        end
    end

    // Lookahead on the previous batch, compute on the one three back
    assign laSel = phaseD - 2'd1;
    assign coSel = phaseD + 2'd1;
    assign laSample = readSide[laSel];
    assign fwSample = writeSide[coSel];
    assign bwSample = readSide[coSel];

    for (genvar c = 0; c < channels; c++) begin : gChannel
        FilterChannel #(.depth(depth), .sampleBits(sampleBits), .channel(c)) channel (
            .clk,
            .rstN,
            .phase(phaseD),
            .batchCount(countD),
            .batchCountRev(countRevD),
            .lookaheadLoad(loadD),
            .lookaheadSample(laSample),
            .forwardSample(fwSample),
            .backwardSample(bwSample),
            .contribution(contrib[c])
        );
    end

    // Sum wraps at state width
    always_comb begin
        channelSum = '0;
        for (int c = 0; c < channels; c++) begin
            channelSum = channelSum + contrib[c];
        end
    end

    always_ff @(posedge clk) begin
        outData <= channelSum;
    end

endmodule

//--- tb/ReconstructionChecker.sv
`timescale 1ns/1ps

module ReconstructionChecker #(
    parameter int depth = 32,
    parameter int sampleBits = 3,
    parameter int channels = 3
) (
    input  logic                                   clk,
    input  logic                                   rstN,
    input  logic [sampleBits-1:0]                  sampleIn,
    input  int                                     sectionId,
    input  logic signed [BatchPkg::stateWidth-1:0] outData,
    input  logic                                   outValid,
    input  logic                                   runDone,
    output int                                     checkedCount,
    output int                                     errorCount,
    output logic                                   reportDone
);

    logic [sampleBits-1:0] samples [$];
    int sections [$];
    logic active = 1'b0;
    logic resetSeen = 1'b0;
    logic seenValid = 1'b0;
    logic reported = 1'b0;
    int checkCount = 0;
    int errors = 0;
    logic signed [BatchPkg::stateWidth-1:0] expected;

    assign checkedCount = checkCount;
    assign errorCount = errors;
    assign reportDone = reported;

    function automatic string sectionName(int id);
        case (id)
            0: return "randomBits";
            1: return "allOnes";
            2: return "alternating";
            3: return "randomTail";
            default: return "drain";
        endcase
    endfunction

    function automatic BatchPkg::complexT wrapPair(longint re, longint im);
        BatchPkg::complexT r;
        r.re = re[BatchPkg::stateWidth-1:0];
        r.im = im[BatchPkg::stateWidth-1:0];
        return r;
    endfunction

    // Exact product, floor shift by the fraction bits, then wrap
    function automatic BatchPkg::complexT scaleBy(BatchPkg::complexT s, BatchPkg::coefT f);
        longint sRe;
        longint sIm;
        longint re;
        longint im;
        sRe = longint'($signed(s.re));
        sIm = longint'($signed(s.im));
        re = (sRe * longint'($signed(f.re)) - sIm * longint'($signed(f.im))) >>> BatchPkg::fracBits;
        im = (sRe * longint'($signed(f.im)) + sIm * longint'($signed(f.re))) >>> BatchPkg::fracBits;
        return wrapPair(re, im);
    endfunction

    function automatic BatchPkg::complexT addPair(BatchPkg::complexT a, BatchPkg::complexT b);
        return wrapPair(longint'($signed(a.re)) + longint'($signed(b.re)),
                        longint'($signed(a.im)) + longint'($signed(b.im)));
    endfunction

    // A one bit adds its coefficient, a zero bit subtracts it
    function automatic BatchPkg::complexT lutValue(int ch, logic [sampleBits-1:0] s);
        BatchPkg::coefT k;
        longint re;
        longint im;
        re = 0;
        im = 0;
        for (int i = 0; i < sampleBits; i++) begin
            k = BatchPkg::inputCoef[ch][i];
            re = s[i] ? re + longint'($signed(k.re)) : re - longint'($signed(k.re));
            im = s[i] ? im + longint'($signed(k.im)) : im - longint'($signed(k.im));
        end
        return wrapPair(re, im);
    endfunction

    function automatic logic signed [BatchPkg::stateWidth-1:0] expectedAt(int n);
        BatchPkg::complexT fw;
        BatchPkg::complexT la;
        BatchPkg::complexT bw;
        BatchPkg::complexT fwW;
        BatchPkg::complexT bwW;
        longint total;
        int next;
        total = 0;
        next = (n / depth + 1) * depth;
        for (int ch = 0; ch < channels; ch++) begin
            fw = '0;
            for (int i = 0; i <= n; i++) begin
                fw = addPair(scaleBy(fw, BatchPkg::forwardFactor[ch]), lutValue(ch, samples[i]));
            end
            // Lookahead over the following batch, newest sample first
            la = '0;
            for (int i = next + depth - 1; i >= next; i--) begin
                la = addPair(scaleBy(la, BatchPkg::backwardFactor[ch]), lutValue(ch, samples[i]));
            end
            // Start state joins the batch's last sample without a factor
            bw = addPair(la, lutValue(ch, samples[next - 1]));
            for (int i = next - 2; i >= n; i--) begin
                bw = addPair(scaleBy(bw, BatchPkg::backwardFactor[ch]), lutValue(ch, samples[i]));
            end
            fwW = scaleBy(fw, BatchPkg::forwardWeight[ch]);
            bwW = scaleBy(bw, BatchPkg::backwardWeight[ch]);
            total = total + longint'($signed(fwW.re)) + longint'($signed(bwW.re));
        end
        return total[BatchPkg::stateWidth-1:0];
    endfunction

    task automatic compareOutput();
        int n;
        n = checkCount;
        seenValid = 1'b1;
        checkCount++;
        if (samples.size() <= 4 * depth) begin
            errors++;
            $display("outValid rose before four batches were complete");
        end else if (samples.size() < (n / depth + 2) * depth) begin
            errors++;
            $display("Output %0d arrived before its lookahead batch was recorded", n);
        end else begin
            expected = expectedAt(n);
            if (outData !== expected) begin
                errors++;
                $display("FAIL %s sample %0d: expected %0d, actual %0d",
                         sectionName(sections[n]), n, expected, outData);
            end
        end
    endtask

    task automatic closeRun();
        int completed;
        int expectedCount;
        completed = samples.size() / depth;
        expectedCount = depth * (completed - 4);
        if (checkCount != expectedCount) begin
            errors++;
            $display("Saw %0d valid outputs, but %0d complete batches call for %0d",
                     checkCount, completed, expectedCount);
        end
        $display("Checks: %0d, errors: %0d", checkCount, errors);
        reported = 1'b1;
    endtask

    always @(posedge clk) begin
        active = rstN;
        if (rstN) begin
            samples.push_back(sampleIn);
            sections.push_back(sectionId);
        end else begin
            resetSeen = 1'b1;
        end
    end

    // Outputs are registered, so they are read half a cycle later
    always @(negedge clk) begin
        if (runDone && !reported) begin
            closeRun();
        end else if (!active) begin
            if (resetSeen && outValid !== 1'b0) begin
                errors++;
                $display("outValid was not low during reset");
            end
        end else if (outValid === 1'b1) begin
            compareOutput();
        end else if (seenValid || outValid !== 1'b0) begin
            errors++;
            $display("outValid dropped or went unknown after output %0d", checkCount);
        end
    end

endmodule

//--- tb/BatchReconstructorTb.sv
`timescale 1ns/1ps

module BatchReconstructorTb;

    localparam int depth = 32;
    localparam int sampleBits = 3;
    localparam int channels = 3;

    // Section ids, in the order the checker names them
    localparam int randomBitsId = 0;
    localparam int allOnesId = 1;
    localparam int alternatingId = 2;
    localparam int randomTailId = 3;
    localparam int drainId = 4;

    localparam int totalBatches = 12 + 6 + 6 + 8;
    // Last batch's outputs end four cycles into the fourth drain batch
    localparam int drainCycles = 4 * depth + 4;
    localparam int watchdogNs = (totalBatches + 6) * depth * 8;

    logic clk;
    logic rstN;
    logic [sampleBits-1:0] sampleIn;
    logic signed [BatchPkg::stateWidth-1:0] outData;
    logic outValid;
    int sectionId;
    logic runDone;
    int checkedCount;
    int errorCount;
    logic reportDone;
    logic [31:0] rng;

    BatchReconstructor #(.depth(depth), .sampleBits(sampleBits), .channels(channels)) UUT (
        .clk, .rstN, .sampleIn, .outData, .outValid);

    ReconstructionChecker #(.depth(depth), .sampleBits(sampleBits), .channels(channels)) refCheck (
        .clk, .rstN, .sampleIn, .sectionId, .outData, .outValid, .runDone,
        .checkedCount, .errorCount, .reportDone);

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    initial begin
        #(watchdogNs);
        $display("Watchdog expired after %0d ns with %0d outputs checked", watchdogNs, checkedCount);
        $display("Result: FAILED");
        $finish;
    end

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    // Called on a falling edge, returns on the falling edge after the last sample
    task automatic runSection(input int id, input int batches);
        logic [sampleBits-1:0] value;
        for (int n = 0; n < batches * depth; n++) begin
            case (id)
                allOnesId: value = '1;
                alternatingId: begin
                    for (int i = 0; i < sampleBits; i++) begin
                        value[i] = i[0] ^ n[0];
                    end
                end
                default: begin
                    rng = xorshift(rng);
                    value = rng[sampleBits-1:0];
                end
            endcase
            sampleIn = value;
            sectionId = id;
            @(negedge clk);
        end
    endtask

    initial begin
        rng = 32'h420fb445;
        rstN = 1'b0;
        sampleIn = '0;
        sectionId = randomBitsId;
        runDone = 1'b0;
        repeat (2) @(posedge clk);
        @(negedge clk);
        rstN = 1'b1;
        runSection(randomBitsId, 12);
        runSection(allOnesId, 6);
        runSection(alternatingId, 6);
        runSection(randomTailId, 8);
        // Filler while the last batches drain out
        sampleIn = '0;
        sectionId = drainId;
        repeat (drainCycles - 1) @(negedge clk);
        @(posedge clk);
        runDone = 1'b1;
        while (!reportDone) begin
            @(posedge clk);
        end
        if (errorCount == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule

//--- sources.f
hw/BatchPkg.sv
hw/BatchRam.sv
hw/CoeffLut.sv
hw/ComplexRecursion.sv
hw/BatchControl.sv
hw/FilterChannel.sv
hw/BatchReconstructor.sv
tb/ReconstructionChecker.sv
tb/BatchReconstructorTb.sv

//--- run.sh
#!/bin/sh
# Builds the testbench with Verilator and runs it from the project root

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
    -f sources.f \
    --top-module BatchReconstructorTb \
    -Mdir obj_dir -o simv
status=$?
if [ $status -ne 0 ]; then
    echo "Verilator build failed with status $status"
    exit 1
fi

./obj_dir/simv > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -qx "Result: PASSED" sim.log; then
    exit 0
fi
echo "Pass message not found in sim.log"
exit 1
